//--- hw/pcieLinkPkg.sv
package pcieLinkPkg;

    // lane masks are sized from each module's LaneCount parameter
    localparam int DefaultLaneCount = 4;

    typedef logic [7:0] symbol_t;
    typedef logic [7:0] linkNum_t;

    typedef enum logic [1:0] {
        ltssmDetect,
        ltssmPolling,
        ltssmConfig,
        ltssmL0
    } ltssmState_t;

    typedef enum logic [3:0] {
        lpifReset = 4'd0,
        lpifActive = 4'd1,
        lpifRetrain = 4'd2
    } lpifState_t;

    typedef enum logic [2:0] {
        osIdle,
        osTs1,
        osTs2,
        osStp,
        osEnd,
        osData
    } osKind_t;

    // K symbols
    localparam symbol_t ComSym = 8'hBC;
    localparam symbol_t PadSym = 8'hF7;
    localparam symbol_t StpSym = 8'hFB;
    localparam symbol_t EndSym = 8'hFD;

    // training set identifiers, sent as data symbols
    localparam symbol_t Ts1Id = 8'h4A;
    localparam symbol_t Ts2Id = 8'h45;

    localparam int TxSetCount = 16;
    localparam int RxSetCount = 8;

    localparam logic [1:0] RegLinkNum = 2'd0;
    localparam logic [1:0] RegStatus = 2'd1;
    localparam logic [1:0] RegRetrains = 2'd2;
    localparam logic [1:0] RegTlpCount = 2'd3;

endpackage

//--- hw/linkConfigRegs.sv
`timescale 1ns/1ps

module linkConfigRegs
    import pcieLinkPkg::*;
#(
    parameter int LaneCount = DefaultLaneCount,
    parameter type laneMask_t = logic [LaneCount-1:0]
)
(
    input  logic CLK,
    input  logic reset,
    input  logic wbCyc,
    input  logic wbStb,
    input  logic wbWe,
    input  logic [1:0] wbAdr,
    input  logic [31:0] wbDatW,
    input  ltssmState_t ltssmState,
    input  laneMask_t detectedLanes,
    input  logic linkUp,
    input  logic retrainPulse,
    input  logic tlpSeen,
    output logic [31:0] wbDatR,
    output logic wbAck,
    output linkNum_t cfgLinkNum
);

    logic wbReq;
    logic [31:0] statusWord;
    logic [15:0] retrainCount;
    logic [15:0] tlpCount;

    // a new request is taken only outside the ack cycle
    assign wbReq = wbCyc && wbStb && !wbAck;

    always_comb
    begin
        statusWord = '0;
        statusWord[0] = linkUp;
        statusWord[2:1] = ltssmState;
        statusWord[8 +: LaneCount] = detectedLanes;
    end

    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            wbAck <= 1'b0;
            cfgLinkNum <= 8'h01;
            retrainCount <= '0;
            tlpCount <= '0;
        end
        else
        begin
            wbAck <= wbReq;
            if (wbReq && wbWe && wbAdr == RegLinkNum)
            begin
                cfgLinkNum <= wbDatW[7:0];
            end
            // both counters saturate
            if (retrainPulse && retrainCount != 16'hFFFF)
            begin
                retrainCount <= retrainCount + 16'd1;
            end
            if (tlpSeen && tlpCount != 16'hFFFF)
            begin
                tlpCount <= tlpCount + 16'd1;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (wbReq)
        begin
            case (wbAdr)
                RegLinkNum: wbDatR <= {24'd0, cfgLinkNum};
                RegStatus: wbDatR <= statusWord;
                RegRetrains: wbDatR <= {16'd0, retrainCount};
                default: wbDatR <= {16'd0, tlpCount};
            endcase
        end
    end

endmodule

//--- hw/ltssmCore.sv
`timescale 1ns/1ps

module ltssmCore
    import pcieLinkPkg::*;
#(
    parameter int LaneCount = DefaultLaneCount,
    parameter int DetectWait = 12,
    parameter type laneMask_t = logic [LaneCount-1:0]
)
(
    input  logic CLK,
    input  logic reset,
    input  lpifState_t lpStateReq,
    input  laneMask_t PhyStatus,
    input  logic [LaneCount-1:0][2:0] RxStatus,
    input  linkNum_t cfgLinkNum,
    input  logic txSetDone,
    input  logic rxTs1Seen,
    input  logic rxTs2Seen,
    input  linkNum_t rxLinkNum,
    output logic detectReq,
    output ltssmState_t ltssmState,
    output osKind_t txKind,
    output linkNum_t txLinkNum,
    output laneMask_t detectedLanes,
    output logic linkUp,
    output lpifState_t plStateSts,
    output logic retrainPulse
);

    localparam int TxCountWidth = $clog2(TxSetCount + 1);
    localparam int RxCountWidth = $clog2(RxSetCount + 1);
    localparam int WaitWidth = $clog2(DetectWait + 1);

    logic [TxCountWidth-1:0] txSets;
    logic [RxCountWidth-1:0] rxSets;
    logic [WaitWidth-1:0] waitCount;
    laneMask_t rxPresent;
    logic rxAnySet;
    logic rxMatch;
    logic txLast;
    logic rxDone;
    logic trainDone;

    // status 3 means a receiver was found on that lane
    always_comb
    begin
        for (int i = 0; i < LaneCount; i++)
        begin
            rxPresent[i] = RxStatus[i] == 3'd3;
        end
    end

    assign rxAnySet = rxTs1Seen || rxTs2Seen;
    assign rxMatch = (ltssmState == ltssmPolling) ? rxAnySet
                                                  : rxTs2Seen && rxLinkNum == cfgLinkNum;
    assign txLast = txSets >= TxCountWidth'(TxSetCount - 1);
    assign rxDone = rxSets == RxCountWidth'(RxSetCount);
    // leave only on a set boundary so the next state starts with a fresh set
    assign trainDone = txSetDone && txLast && rxDone;

    always_comb
    begin
        case (ltssmState)
            ltssmPolling: txKind = osTs1;
            ltssmConfig: txKind = osTs2;
            ltssmL0: txKind = osData;
            default: txKind = osIdle;
        endcase
    end

    assign txLinkNum = cfgLinkNum;
    assign linkUp = ltssmState == ltssmL0;
    assign plStateSts = linkUp ? lpifActive : lpifReset;

    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            ltssmState <= ltssmDetect;
            detectReq <= 1'b0;
            waitCount <= '0;
            txSets <= '0;
            rxSets <= '0;
            detectedLanes <= '0;
            retrainPulse <= 1'b0;
        end
        else
        begin
            retrainPulse <= 1'b0;
            case (ltssmState)
                ltssmDetect:
                begin
                    if (waitCount != '0)
                    begin
                        waitCount <= waitCount - 1'b1;
                    end
                    else if (!detectReq)
                    begin
                        detectReq <= 1'b1;
                    end
                    else if (&PhyStatus)
                    begin
                        detectReq <= 1'b0;
                        detectedLanes <= rxPresent;
                        if (&rxPresent)
                        begin
                            ltssmState <= ltssmPolling;
                        end
                        else
                        begin
                            waitCount <= WaitWidth'(DetectWait);
                        end
                    end
                end
                ltssmPolling, ltssmConfig:
                begin
                    if (txSetDone && !txLast)
                    begin
                        txSets <= txSets + 1'b1;
                    end
                    // a set that does not match breaks the run
                    if (rxMatch && !rxDone)
                    begin
                        rxSets <= rxSets + 1'b1;
                    end
                    else if (rxAnySet && !rxMatch)
                    begin
                        rxSets <= '0;
                    end
                    if (trainDone)
                    begin
                        txSets <= '0;
                        rxSets <= '0;
                        ltssmState <= (ltssmState == ltssmPolling) ? ltssmConfig : ltssmL0;
                    end
                end
                ltssmL0:
                begin
                    if (lpStateReq == lpifRetrain)
                    begin
                        ltssmState <= ltssmConfig;
                        retrainPulse <= 1'b1;
                    end
                    else if (lpStateReq == lpifReset)
                    begin
                        ltssmState <= ltssmDetect;
                    end
                end
            endcase
        end
    end

endmodule

//--- hw/txFramer.sv
`timescale 1ns/1ps

module txFramer
    import pcieLinkPkg::*;
#(
    parameter int LaneCount = DefaultLaneCount,
    parameter type laneMask_t = logic [LaneCount-1:0]
)
(
    input  logic CLK,
    input  logic reset,
    input  ltssmState_t ltssmState,
    input  osKind_t txKind,
    input  linkNum_t txLinkNum,
    input  logic lpIrdy,
    input  symbol_t [LaneCount-1:0] lpData,
    input  logic lpTlpStart,
    input  logic lpTlpEnd,
    output logic plTrdy,
    output logic txSetDone,
    output symbol_t [LaneCount-1:0] TxData,
    output laneMask_t TxDataK,
    output laneMask_t TxDataValid,
    output laneMask_t TxElecIdle
);

    logic [1:0] symIdx;
    osKind_t tlpPhase;
    osKind_t nextPhase;
    logic sendingSet;
    logic setK;
    symbol_t setSym;
    symbol_t [LaneCount-1:0] nextData;
    laneMask_t nextK;
    logic nextValid;
    logic nextTrdy;

    assign sendingSet = ltssmState != ltssmL0 && (txKind == osTs1 || txKind == osTs2);
    assign txSetDone = sendingSet && symIdx == 2'd3;

    // TS1 carries PAD in the link field, TS2 the configured link number
    always_comb
    begin
        setK = 1'b0;
        case (symIdx)
            2'd0:
            begin
                setSym = ComSym;
                setK = 1'b1;
            end
            2'd1:
            begin
                setSym = (txKind == osTs1) ? PadSym : txLinkNum;
                setK = txKind == osTs1;
            end
            2'd2: setSym = 8'h00;
            default: setSym = (txKind == osTs1) ? Ts1Id : Ts2Id;
        endcase
    end

    always_comb
    begin
        nextData = lpData;
        nextK = '0;
        nextValid = 1'b0;
        nextPhase = tlpPhase;
        nextTrdy = plTrdy;
        if (ltssmState != ltssmL0)
        begin
            nextPhase = osIdle;
            nextTrdy = 1'b0;
            if (sendingSet)
            begin
                nextData = {LaneCount{setSym}};
                nextK = {LaneCount{setK}};
                nextValid = 1'b1;
            end
        end
        else
        begin
            case (tlpPhase)
                osIdle:
                begin
                    if (lpIrdy && lpTlpStart)
                    begin
                        nextPhase = osStp;
                    end
                end
                osStp:
                begin
                    nextData = {LaneCount{StpSym}};
                    nextK = '1;
                    nextValid = 1'b1;
                    nextTrdy = 1'b1;
                    nextPhase = osData;
                end
                osData:
                begin
                    // a gap in lpIrdy becomes an idle cycle on the lanes
                    if (lpIrdy && plTrdy)
                    begin
                        nextValid = 1'b1;
                        if (lpTlpEnd)
                        begin
                            nextTrdy = 1'b0;
                            nextPhase = osEnd;
                        end
                    end
                end
                osEnd:
                begin
                    nextData = {LaneCount{EndSym}};
                    nextK = '1;
                    nextValid = 1'b1;
                    nextPhase = osIdle;
                end
                default: nextPhase = osIdle;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            symIdx <= '0;
            tlpPhase <= osIdle;
            plTrdy <= 1'b0;
            TxDataK <= '0;
            TxDataValid <= '0;
            TxElecIdle <= '1;
        end
        else
        begin
            symIdx <= sendingSet ? symIdx + 2'd1 : 2'd0;
            tlpPhase <= nextPhase;
            plTrdy <= nextTrdy;
            TxDataK <= nextK;
            TxDataValid <= {LaneCount{nextValid}};
            TxElecIdle <= {LaneCount{ltssmState == ltssmDetect}};
        end
    end

    always_ff @(posedge CLK)
    begin
        TxData <= nextData;
    end

endmodule

//--- hw/rxDeframer.sv
`timescale 1ns/1ps

module rxDeframer
    import pcieLinkPkg::*;
#(
    parameter int LaneCount = DefaultLaneCount,
    parameter type laneMask_t = logic [LaneCount-1:0]
)
(
    input  logic CLK,
    input  logic reset,
    input  symbol_t [LaneCount-1:0] RxData,
    input  laneMask_t RxDataK,
    input  laneMask_t RxDataValid,
    output logic rxTs1Seen,
    output logic rxTs2Seen,
    output linkNum_t rxLinkNum,
    output symbol_t [LaneCount-1:0] plData,
    output logic plValid,
    output logic plTlpStart,
    output logic plTlpEnd,
    output logic tlpSeen
);

    symbol_t [LaneCount-1:0] r1Data;
    symbol_t [LaneCount-1:0] r2Data;
    laneMask_t r1K;
    logic r1Valid;
    logic r1Com;
    logic r1Stp;
    logic r1End;
    logic r1Alike;
    logic r1NoK;
    logic inTlp;
    logic prevStp;
    logic r2Valid;
    logic r2Start;
    logic [1:0] osPos;
    logic osOk;
    linkNum_t osLink;

    // whole-link decode of the registered input cycle
    always_comb
    begin
        r1Com = r1Valid;
        r1Stp = r1Valid;
        r1End = r1Valid;
        r1Alike = 1'b1;
        for (int i = 0; i < LaneCount; i++)
        begin
            r1Com = r1Com && r1K[i] && r1Data[i] == ComSym;
            r1Stp = r1Stp && r1K[i] && r1Data[i] == StpSym;
            r1End = r1End && r1K[i] && r1Data[i] == EndSym;
            r1Alike = r1Alike && r1K[i] == r1K[0] && r1Data[i] == r1Data[0];
        end
    end

    assign r1NoK = r1K == '0;
    assign tlpSeen = plValid && plTlpEnd;

    always_ff @(posedge CLK)
    begin
        r1Data <= RxData;
        r1K <= RxDataK;
        r2Data <= r1Data;
        plData <= r2Data;
    end

    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            r1Valid <= 1'b0;
            inTlp <= 1'b0;
            prevStp <= 1'b0;
            r2Valid <= 1'b0;
            r2Start <= 1'b0;
            plValid <= 1'b0;
            plTlpStart <= 1'b0;
            plTlpEnd <= 1'b0;
        end
        else
        begin
            r1Valid <= &RxDataValid;
            prevStp <= r1Stp;
            if (r1Stp)
            begin
                inTlp <= 1'b1;
            end
            else if (r1End)
            begin
                inTlp <= 1'b0;
            end
            r2Valid <= r1Valid && r1NoK && inTlp;
            r2Start <= prevStp;
            // the beat in r2 is released once r1 shows what follows it
            plValid <= r2Valid;
            plTlpStart <= r2Valid && r2Start;
            plTlpEnd <= r2Valid && r1End;
        end
    end

    // ordered set parser, osPos 0 means waiting for COM
    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            osPos <= '0;
            osOk <= 1'b0;
            osLink <= '0;
            rxLinkNum <= '0;
            rxTs1Seen <= 1'b0;
            rxTs2Seen <= 1'b0;
        end
        else
        begin
            rxTs1Seen <= 1'b0;
            rxTs2Seen <= 1'b0;
            if (r1Com)
            begin
                osPos <= 2'd1;
                osOk <= 1'b1;
            end
            else if (osPos != 2'd0)
            begin
                osPos <= r1Valid ? osPos + 2'd1 : 2'd0;
                osOk <= osOk && r1Alike;
                case (osPos)
                    2'd1: osLink <= r1Data[0];
                    2'd2: osOk <= osOk && r1Alike && r1NoK && r1Data[0] == 8'h00;
                    default:
                    begin
                        if (r1Valid && osOk && r1Alike && r1NoK)
                        begin
                            rxTs1Seen <= r1Data[0] == Ts1Id;
                            rxTs2Seen <= r1Data[0] == Ts2Id;
                            rxLinkNum <= osLink;
                        end
                    end
                endcase
            end
        end
    end

endmodule

//--- hw/pcieLink.sv
`timescale 1ns/1ps

module pcieLink
    import pcieLinkPkg::*;
#(
    parameter int LaneCount = DefaultLaneCount,
    parameter int DetectWait = 12,
    parameter type laneMask_t = logic [LaneCount-1:0]
)
(
    input  logic CLK,
    input  logic reset,
    output symbol_t [LaneCount-1:0] TxData,
    output laneMask_t TxDataK,
    output laneMask_t TxDataValid,
    output laneMask_t TxElecIdle,
    output laneMask_t TxDetectRx,
    input  symbol_t [LaneCount-1:0] RxData,
    input  laneMask_t RxDataK,
    input  laneMask_t RxDataValid,
    input  logic [LaneCount-1:0][2:0] RxStatus,
    input  laneMask_t PhyStatus,
    input  logic lpIrdy,
    input  symbol_t [LaneCount-1:0] lpData,
    input  logic lpTlpStart,
    input  logic lpTlpEnd,
    output logic plTrdy,
    input  lpifState_t lpStateReq,
    output lpifState_t plStateSts,
    output logic plLinkUp,
    output symbol_t [LaneCount-1:0] plData,
    output logic plValid,
    output logic plTlpStart,
    output logic plTlpEnd,
    input  logic wbCyc,
    input  logic wbStb,
    input  logic wbWe,
    input  logic [1:0] wbAdr,
    input  logic [31:0] wbDatW,
    output logic [31:0] wbDatR,
    output logic wbAck
);

    ltssmState_t ltssmState;
    osKind_t txKind;
    linkNum_t txLinkNum;
    linkNum_t cfgLinkNum;
    linkNum_t rxLinkNum;
    laneMask_t detectedLanes;
    logic detectReq;
    logic retrainPulse;
    logic txSetDone;
    logic rxTs1Seen;
    logic rxTs2Seen;
    logic tlpSeen;

    // one detect request drives every lane
    assign TxDetectRx = {LaneCount{detectReq}};

    linkConfigRegs #(
        .LaneCount(LaneCount),
        .laneMask_t(laneMask_t)
    ) linkConfigRegs_i (
        .*,
        .linkUp(plLinkUp)
    );

    ltssmCore #(
        .LaneCount(LaneCount),
        .DetectWait(DetectWait),
        .laneMask_t(laneMask_t)
    ) ltssmCore_i (
        .*,
        .linkUp(plLinkUp)
    );

    txFramer #(
        .LaneCount(LaneCount),
        .laneMask_t(laneMask_t)
    ) txFramer_i (
        .*
    );

    rxDeframer #(
        .LaneCount(LaneCount),
        .laneMask_t(laneMask_t)
    ) rxDeframer_i (
        .*
    );

endmodule

//--- bench/pcieLinkModel.svh
`ifndef PCIE_LINK_MODEL_SVH
`define PCIE_LINK_MODEL_SVH

// beats in send order with their framing marks
symbol_t [LaneCount-1:0] beatData[$];
logic beatStart[$];
logic beatEnd[$];
int sentTlps = 0;
int retrains = 0;

int checkCount = 0;
int errorCount = 0;
int testCount = 0;
int failedTests = 0;
int errorsBefore = 0;

// linkUp in bit 0, state in bits 2:1, lane mask from bit 8
function automatic logic [31:0] statusFor(input logic up, input ltssmState_t state,
                                          input logic [LaneCount-1:0] lanes);
    logic [31:0] word;
    word = '0;
    word[0] = up;
    word[2:1] = state;
    word[8 +: LaneCount] = lanes;
    return word;
endfunction

task automatic expectEqual(input string what, input logic [31:0] got,
                           input logic [31:0] want);
    checkCount++;
    assert (got === want)
    else
    begin
        $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, want);
        errorCount++;
    end
endtask

task automatic recordBeat(input symbol_t [LaneCount-1:0] data, input logic first,
                          input logic last);
    beatData.push_back(data);
    beatStart.push_back(first);
    beatEnd.push_back(last);
    if (last)
    begin
        sentTlps++;
    end
endtask

task automatic checkBeat(input symbol_t [LaneCount-1:0] data, input logic first,
                         input logic last);
    checkCount++;
    assert (beatData.size() != 0)
    else
    begin
        $display("ERROR at %0t ns: a beat arrived on plData that was never sent", $time);
        errorCount++;
    end
    if (beatData.size() != 0)
    begin
        expectEqual("plData", data, beatData.pop_front());
        expectEqual("plTlpStart", first, beatStart.pop_front());
        expectEqual("plTlpEnd", last, beatEnd.pop_front());
    end
endtask

task automatic reportTest(input string name);
    testCount++;
    if (errorCount == errorsBefore)
    begin
        $display("test %0d %s: ok", testCount, name);
    end
    else
    begin
        $display("test %0d %s: %0d errors", testCount, name, errorCount - errorsBefore);
        failedTests++;
    end
    errorsBefore = errorCount;
endtask

`endif

//--- bench/pcieLinkTb.sv
`timescale 1ns/1ps

module pcieLinkTb
    import pcieLinkPkg::*;
();

    localparam int LaneCount = DefaultLaneCount;
    localparam int DetectWait = 12;
    localparam int TlpTotal = 20;
    // training takes a few hundred cycles and the traffic about as many again
    localparam int TimeoutCycles = 4000;

    logic CLK = 1'b0;
    logic reset = 1'b1;
    symbol_t [LaneCount-1:0] TxData;
    logic [LaneCount-1:0] TxDataK;
    logic [LaneCount-1:0] TxDataValid;
    logic [LaneCount-1:0] TxElecIdle;
    logic [LaneCount-1:0] TxDetectRx;
    symbol_t [LaneCount-1:0] RxData;
    logic [LaneCount-1:0] RxDataK;
    logic [LaneCount-1:0] RxDataValid;
    logic [LaneCount-1:0][2:0] RxStatus;
    logic [LaneCount-1:0] PhyStatus;
    logic lpIrdy;
    symbol_t [LaneCount-1:0] lpData;
    logic lpTlpStart;
    logic lpTlpEnd;
    logic plTrdy;
    lpifState_t lpStateReq;
    lpifState_t plStateSts;
    logic plLinkUp;
    symbol_t [LaneCount-1:0] plData;
    logic plValid;
    logic plTlpStart;
    logic plTlpEnd;
    logic wbCyc;
    logic wbStb;
    logic wbWe;
    logic [1:0] wbAdr;
    logic [31:0] wbDatW;
    logic [31:0] wbDatR;
    logic wbAck;

    integer seed = 42;
    int cycleCount = 0;

    `include "pcieLinkModel.svh"

    pcieLink #(
        .LaneCount(LaneCount),
        .DetectWait(DetectWait)
    ) pcieLink_i (
        .*
    );

    // PIPE loopback
    assign RxData = TxData;
    assign RxDataK = TxDataK;
    assign RxDataValid = TxDataValid;

    always #50 CLK = ~CLK;

    always @(posedge CLK)
    begin
        cycleCount++;
        if (cycleCount >= TimeoutCycles)
        begin
            $display("timeout: the run did not finish within %0d cycles", TimeoutCycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // received beats checked against the model queue
    always @(negedge CLK)
    begin
        if (!reset && plValid)
        begin
            checkBeat(plData, plTlpStart, plTlpEnd);
        end
    end

    task automatic nextCycle();
        @(posedge CLK);
        #10;
    endtask

    task automatic busAccess(input logic write, input logic [1:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        waited = 0;
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe = write;
        wbAdr = addr;
        wbDatW = wdata;
        do
        begin
            nextCycle();
            waited++;
        end
        while (!wbAck);
        rdata = wbDatR;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        expectEqual("wbAck latency", waited, 1);
        // bus idle for one cycle between accesses
        nextCycle();
    endtask

    task automatic answerDetect(input logic [LaneCount-1:0][2:0] status);
        int delay;
        while (TxDetectRx != '1)
        begin
            nextCycle();
        end
        // detection takes a variable time in the PHY
        delay = 1 + ($unsigned($random(seed)) % 4);
        repeat (delay) nextCycle();
        PhyStatus = '1;
        RxStatus = status;
        nextCycle();
        PhyStatus = '0;
        RxStatus = '0;
    endtask

    task automatic sendTlp(input int beats);
        symbol_t [LaneCount-1:0] data;
        logic taken;
        int gap;
        for (int b = 0; b < beats; b++)
        begin
            data = $random(seed);
            lpIrdy = 1'b1;
            lpData = data;
            lpTlpStart = b == 0;
            lpTlpEnd = b == beats - 1;
            taken = 1'b0;
            // plTrdy is stable at the falling edge before the accepting edge
            while (!taken)
            begin
                @(negedge CLK);
                taken = plTrdy;
                nextCycle();
            end
            recordBeat(data, b == 0, b == beats - 1);
            lpIrdy = 1'b0;
            lpTlpStart = 1'b0;
            lpTlpEnd = 1'b0;
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) nextCycle();
        end
    endtask

    task automatic awaitLinkUp();
        while (!plLinkUp)
        begin
            nextCycle();
        end
    endtask

    task automatic awaitDrain();
        while (beatData.size() != 0)
        begin
            nextCycle();
        end
        repeat (2) nextCycle();
    endtask

    initial
    begin
        logic [31:0] readData;
        linkNum_t linkNum;
        lpIrdy = 1'b0;
        lpData = '0;
        lpTlpStart = 1'b0;
        lpTlpEnd = 1'b0;
        lpStateReq = lpifActive;
        PhyStatus = '0;
        RxStatus = '0;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        wbAdr = '0;
        wbDatW = '0;
        repeat (3) @(posedge CLK);
        #10;
        reset = 1'b0;

        linkNum = $random(seed);
        busAccess(1'b1, RegLinkNum, {24'd0, linkNum}, readData);
        busAccess(1'b0, RegLinkNum, 32'd0, readData);
        expectEqual("RegLinkNum readback", readData, {24'd0, linkNum});
        busAccess(1'b1, RegStatus, $random(seed), readData);
        busAccess(1'b0, RegStatus, 32'd0, readData);
        expectEqual("RegStatus after write", readData, statusFor(1'b0, ltssmDetect, '0));
        // a write elsewhere must not reach the link number
        busAccess(1'b0, RegLinkNum, 32'd0, readData);
        expectEqual("RegLinkNum after status write", readData, {24'd0, linkNum});
        reportTest("wishbone");

        // no receiver on lane 2 in the first attempt
        answerDetect({3'd3, 3'd0, 3'd3, 3'd3});
        busAccess(1'b0, RegStatus, 32'd0, readData);
        expectEqual("status after failed detect", readData,
                    statusFor(1'b0, ltssmDetect, 4'b1011));
        expectEqual("plLinkUp in Detect", plLinkUp, 1'b0);
        expectEqual("TxElecIdle in Detect", TxElecIdle, {LaneCount{1'b1}});
        answerDetect({LaneCount{3'd3}});
        reportTest("detect retry");

        awaitLinkUp();
        expectEqual("plStateSts in L0", plStateSts, lpifActive);
        expectEqual("TxElecIdle in L0", TxElecIdle, '0);
        expectEqual("TxDetectRx in L0", TxDetectRx, '0);
        busAccess(1'b0, RegStatus, 32'd0, readData);
        expectEqual("status in L0", readData, statusFor(1'b1, ltssmL0, '1));
        reportTest("training");

        for (int t = 0; t < TlpTotal; t++)
        begin
            sendTlp(1 + ($unsigned($random(seed)) % 5));
        end
        awaitDrain();
        busAccess(1'b0, RegTlpCount, 32'd0, readData);
        expectEqual("RegTlpCount", readData, sentTlps);
        reportTest("data");

        lpStateReq = lpifRetrain;
        retrains++;
        nextCycle();
        lpStateReq = lpifActive;
        expectEqual("plLinkUp after retrain request", plLinkUp, 1'b0);
        awaitLinkUp();
        busAccess(1'b0, RegRetrains, 32'd0, readData);
        expectEqual("RegRetrains", readData, retrains);
        sendTlp(3);
        awaitDrain();
        busAccess(1'b0, RegTlpCount, 32'd0, readData);
        expectEqual("RegTlpCount after retrain", readData, sentTlps);
        reportTest("retrain");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 testCount, failedTests, checkCount, errorCount);
        if (errorCount == 0)
        begin
            $display("SIMULATION PASSED");
        end
        else
        begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- pcieLink.f
+incdir+bench
hw/pcieLinkPkg.sv
hw/linkConfigRegs.sv
hw/ltssmCore.sv
hw/txFramer.sv
hw/rxDeframer.sv
hw/pcieLink.sv
bench/pcieLinkTb.sv

//--- Bender.yml
package:
  name: pcieLink

sources:
  - hw/pcieLinkPkg.sv
  - hw/linkConfigRegs.sv
  - hw/ltssmCore.sv
  - hw/txFramer.sv
  - hw/rxDeframer.sv
  - hw/pcieLink.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/pcieLinkTb.sv
